// ==== tb.f ====
mii_pkg.sv
plca_pkg.sv
plca_rx_decode.sv
plca_tx_buffer.sv
plca_control.sv
plca_tx_out.sv
plca_rs.sv
tb_clock_gen.sv
tb_plca_rs.sv

// ==== Makefile ====
TOP := tb_plca_rs

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb_plca_rs.sv ====
`timescale 1ns/1ns

module tb_plca_rs
    import mii_pkg::*;
    import plca_pkg::*;
();

    // --------------------
    // Test constants
    // --------------------

    localparam int BEACON_LEN   = 4;             // DUT defaults
    localparam int TO_CYCLES    = 8;
    localparam int BUF_DEPTH    = 16;
    localparam int RESET_CYCLES = 16;
    localparam int NODES        = 4;             // node_count for every test
    localparam int PERIOD       = BEACON_LEN + NODES * TO_CYCLES;   // Quiet cycle length
    localparam int RX_OFFSET    = 2;             // to_timer cycles before the foreign frame
    localparam int RX_LEN       = 12;            // Cycles of RX_DV in opportunity 1
    localparam int FOLLOW_ID    = 2;
    localparam int QUIET_WAIT   = 20;            // Follower idle cycles before any BEACON
    localparam int TIMEOUT_CYCLES = 2 * RESET_CYCLES + 12 * PERIOD + 4 * BUF_DEPTH + RX_LEN;

    // Line words written out from the code table, not taken from the RTL
    localparam mii_tx_t BEACON_WORD = '{txd: 4'b0010, tx_en: 1'b0, tx_er: 1'b1};
    localparam mii_tx_t COMMIT_WORD = '{txd: 4'b0011, tx_en: 1'b0, tx_er: 1'b1};
    localparam mii_tx_t IDLE_WORD   = '{txd: 4'b0000, tx_en: 1'b0, tx_er: 1'b0};

    logic        TX_CLK;
    logic        arst_n;
    logic        reset_req;
    plca_cfg_t   cfg;
    mac_nibble_t mac_in;
    logic        mac_valid;
    logic        credit_return;
    mii_rx_t     mii_rx;
    mii_tx_t     mii_tx;

    int          cycle;                          // Rising edges since time zero
    int          spent;                          // Credits used by pushes
    int          returned;                       // credit_return pulses seen
    logic [15:0] lfsr;
    nibble_t     sent_q[$];                      // Nibbles of the frame in flight

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .reset_req (reset_req),
        .TX_CLK    (TX_CLK),
        .arst_n    (arst_n)
    );

    plca_rs u_dut (
        .TX_CLK        (TX_CLK),
        .arst_n        (arst_n),
        .cfg           (cfg),
        .mac_in        (mac_in),
        .mac_valid     (mac_valid),
        .credit_return (credit_return),
        .mii_rx        (mii_rx),
        .mii_tx        (mii_tx)
    );

    always @(posedge TX_CLK)
    begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES)
        begin
            $display("Test FAILED");
            $fatal(1, "simulation timeout after %0d cycles", cycle);
        end
    end

    always @(negedge TX_CLK)
    begin
        if (credit_return)
            returned++;                          // One pulse gives back one credit
    end

    // --------------------
    // Helpers
    // --------------------

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned take_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);              // One step per bit taken
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int credits_held();
        return BUF_DEPTH - spent + returned;
    endfunction

    task automatic check_mii(string name, mii_tx_t exp, mii_tx_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected txd=%h tx_en=%b tx_er=%b, %s",
                     name, exp.txd, exp.tx_en, exp.tx_er,
                     $sformatf("actual txd=%h tx_en=%b tx_er=%b",
                               act.txd, act.tx_en, act.tx_er));
            $display("Test FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_nibble(string name, nibble_t exp, nibble_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected nibble %h, actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp)
        begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // All tasks below start and end on a falling edge
    task automatic push_frame(input int len);
        mac_nibble_t word;
        sent_q.delete();
        for (int i = 0; i < len; i++)
        begin
            mac_valid = 1'b0;
            while (credits_held() == 0)
                @(negedge TX_CLK);               // No credit left, wait for a return
            word.data = nibble_t'(take_bits(4));
            word.last = (i == len - 1);
            mac_in    = word;
            mac_valid = 1'b1;
            sent_q.push_back(word.data);
            spent++;
            @(negedge TX_CLK);
        end
        mac_valid = 1'b0;
        mac_in    = '0;
    endtask

    task automatic wait_beacon_start(string name, output int t);
        logic prev;
        logic cur;
        cur = (mii_tx == BEACON_WORD);
        do
        begin
            prev = cur;
            @(negedge TX_CLK);
            cur = (mii_tx == BEACON_WORD);
            check_count(name, 0, mii_tx.tx_en);  // Nobody owns a frame here
        end
        while (!cur || prev);
        t = cycle;
    endtask

    task automatic wait_commit(string name, input logic quiet, output int t);
        while (mii_tx != COMMIT_WORD)
        begin
            if (quiet)
                check_mii(name, IDLE_WORD, mii_tx);
            else
                check_count(name, 0, mii_tx.tx_en);
            @(negedge TX_CLK);
        end
        t = cycle;
    endtask

    task automatic expect_frame(string name);
        mii_tx_t exp;
        foreach (sent_q[i])
        begin
            @(negedge TX_CLK);
            exp = '{txd: sent_q[i], tx_en: 1'b1, tx_er: 1'b0};
            check_nibble(name, sent_q[i], mii_tx.txd);
            check_mii(name, exp, mii_tx);
        end
        @(negedge TX_CLK);
        check_mii(name, IDLE_WORD, mii_tx);      // Opportunity over, line idle again
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic test_beacon();
        int t0;
        wait_beacon_start("test_beacon", t0);
        for (int i = 0; i < BEACON_LEN; i++)
        begin
            check_mii("test_beacon", BEACON_WORD, mii_tx);
            @(negedge TX_CLK);
        end
        check_mii("test_beacon", IDLE_WORD, mii_tx);
    endtask

    task automatic test_cycle_period();
        int t0;
        int t1;
        wait_beacon_start("test_cycle_period", t0);
        wait_beacon_start("test_cycle_period", t1);
        check_count("test_cycle_period", PERIOD, t1 - t0);
    endtask

    task automatic test_own_frame();
        int t;
        push_frame(int'(take_bits(4)) + 1);      // 1 to BUF_DEPTH nibbles
        wait_commit("test_own_frame", 1'b0, t);
        expect_frame("test_own_frame");
    endtask

    task automatic test_credits();
        int r0;
        int t;
        check_count("test_credits", BUF_DEPTH, credits_held());
        r0 = returned;
        push_frame(BUF_DEPTH);
        check_count("test_credits", 0, credits_held());   // Every credit is spent
        wait_commit("test_credits", 1'b0, t);
        expect_frame("test_credits");
        @(negedge TX_CLK);
        check_count("test_credits", BUF_DEPTH, returned - r0);
        check_count("test_credits", BUF_DEPTH, credits_held());
    endtask

    task automatic test_receive_defer();
        int t0;
        int t1;
        wait_beacon_start("test_receive_defer", t0);
        // Opportunity 1 starts BEACON_LEN + TO_CYCLES - 1 cycles after the BEACON on the pins
        repeat (BEACON_LEN + TO_CYCLES - 2 + RX_OFFSET)
        begin
            @(negedge TX_CLK);
            check_count("test_receive_defer", 0, mii_tx.tx_en);
        end
        for (int i = 0; i < RX_LEN; i++)
        begin
            mii_rx = '{rxd: nibble_t'(take_bits(4)), rx_dv: 1'b1, rx_er: 1'b0};
            check_count("test_receive_defer", 0, mii_tx.tx_en);
            @(negedge TX_CLK);
        end
        mii_rx = '0;
        wait_beacon_start("test_receive_defer", t1);
        // Timer runs RX_OFFSET cycles, holds RX_LEN, then RECEIVE and NEXT_TO close it
        check_count("test_receive_defer",
                    PERIOD + RX_OFFSET + RX_LEN + 2 - TO_CYCLES, t1 - t0);
    endtask

    task automatic test_follower();
        int b_last;
        int t;
        reset_req = 1'b1;
        @(negedge TX_CLK);
        cfg       = '{plca_en: 1'b1, local_id: node_id_t'(FOLLOW_ID),
                      node_count: node_id_t'(NODES)};
        reset_req = 1'b0;
        @(posedge arst_n);
        b_last = cycle;
        push_frame(int'(take_bits(4)) + 1);
        repeat (QUIET_WAIT)
        begin
            check_mii("test_follower", IDLE_WORD, mii_tx);   // No BEACON before one is heard
            @(negedge TX_CLK);
        end
        for (int i = 0; i < BEACON_LEN; i++)
        begin
            mii_rx = '{rxd: 4'b0010, rx_dv: 1'b0, rx_er: 1'b1};
            b_last = cycle;
            check_mii("test_follower", IDLE_WORD, mii_tx);
            @(negedge TX_CLK);
        end
        mii_rx = '0;
        wait_commit("test_follower", 1'b1, t);
        // RX register, beacon_end and the restart take three cycles, COMMIT and TX register two
        check_count("test_follower", 5 + FOLLOW_ID * TO_CYCLES, t - b_last);
        expect_frame("test_follower");
    endtask

    initial
    begin
        cfg       = '{plca_en: 1'b1, local_id: 8'd0, node_count: node_id_t'(NODES)};
        mac_in    = '0;
        mac_valid = 1'b0;
        mii_rx    = '0;
        reset_req = 1'b0;
        cycle     = 0;
        spent     = 0;
        returned  = 0;
        lfsr      = 16'd21;
        @(posedge arst_n);                       // Released on a falling edge
        test_beacon();
        test_cycle_period();
        test_own_frame();
        test_credits();
        test_receive_defer();
        test_follower();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
)
(
    input  logic reset_req,
    output logic TX_CLK,
    output logic arst_n
);

    initial
    begin
        TX_CLK = 1'b0;
        forever
            #(PERIOD_NS / 2) TX_CLK = ~TX_CLK;   // Free running transmit clock
    end

    // Release always lands on a falling edge, away from the DUT's rising edge
    initial
    begin
        arst_n = 1'b0;
        forever
        begin
            repeat (RESET_CYCLES) @(negedge TX_CLK);
            arst_n = 1'b1;
            @(posedge reset_req);                // A new request starts another reset
            arst_n = 1'b0;
        end
    end

endmodule

// ==== plca_rs.sv ====
`timescale 1ns/1ns

module plca_rs
    import mii_pkg::*;
    import plca_pkg::*;
#(
    parameter int BEACON_LEN = 4,
    parameter int TO_CYCLES  = 8,
    parameter int BUF_DEPTH  = 16
)
(
    input  logic        TX_CLK,
    input  logic        arst_n,
    input  plca_cfg_t   cfg,
    input  mac_nibble_t mac_in,
    input  logic        mac_valid,
    output logic        credit_return,
    input  mii_rx_t     mii_rx,
    output mii_tx_t     mii_tx
);

    // --------------------
    // Internal wiring
    // --------------------

    rx_cmd_t     rx_cmd;
    logic        receiving;
    logic        beacon_end;
    logic        frame_pending;
    mac_nibble_t head;                           // Oldest stored nibble
    logic        pop;
    tx_cmd_t     tx_cmd;

    plca_rx_decode u_rx_decode (
        .TX_CLK     (TX_CLK),
        .arst_n     (arst_n),
        .mii_rx     (mii_rx),
        .rx_cmd     (rx_cmd),
        .receiving  (receiving),
        .beacon_end (beacon_end)
    );

    plca_tx_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_tx_buffer (
        .TX_CLK        (TX_CLK),
        .arst_n        (arst_n),
        .mac_in        (mac_in),
        .mac_valid     (mac_valid),
        .pop           (pop),
        .head          (head),
        .frame_pending (frame_pending),
        .credit_return (credit_return)
    );

    plca_control #(
        .BEACON_LEN (BEACON_LEN),
        .TO_CYCLES  (TO_CYCLES)
    ) u_control (
        .TX_CLK        (TX_CLK),
        .arst_n        (arst_n),
        .cfg           (cfg),
        .rx_cmd        (rx_cmd),
        .receiving     (receiving),
        .beacon_end    (beacon_end),
        .frame_pending (frame_pending),
        .head          (head),
        .tx_cmd        (tx_cmd),
        .pop           (pop)
    );

    plca_tx_out u_tx_out (
        .TX_CLK (TX_CLK),
        .arst_n (arst_n),
        .tx_cmd (tx_cmd),
        .head   (head),
        .mii_tx (mii_tx)
    );

endmodule

// ==== plca_tx_out.sv ====
`timescale 1ns/1ns

module plca_tx_out
    import mii_pkg::*;
    import plca_pkg::*;
(
    input  logic        TX_CLK,
    input  logic        arst_n,
    input  tx_cmd_t     tx_cmd,
    input  mac_nibble_t head,
    output mii_tx_t     mii_tx
);

    localparam mii_tx_t IDLE_WORD = '{txd: 4'h0, tx_en: 1'b0, tx_er: 1'b0};

    // Each command lands on the pins one cycle after it is issued
    always_ff @(posedge TX_CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mii_tx <= IDLE_WORD;
        end
        else
        begin
            case (tx_cmd)
                TX_BEACON: mii_tx <= '{txd: BEACON_CODE, tx_en: 1'b0, tx_er: 1'b1};
                TX_COMMIT: mii_tx <= '{txd: COMMIT_CODE, tx_en: 1'b0, tx_er: 1'b1};
                TX_DATA:   mii_tx <= '{txd: head.data, tx_en: 1'b1, tx_er: 1'b0};
                default:   mii_tx <= IDLE_WORD;
            endcase
        end
    end

    a_en_er_exclusive: assert property (@(posedge TX_CLK) disable iff (!arst_n)
        !(mii_tx.tx_en && mii_tx.tx_er))
        else $error("TX_EN and TX_ER high together");

    // Data on the line is always announced by a COMMIT in the cycle before
    a_commit_before_data: assert property (@(posedge TX_CLK) disable iff (!arst_n)
        $rose(mii_tx.tx_en) |-> $past(mii_tx.tx_er && (mii_tx.txd == COMMIT_CODE)))
        else $error("Frame started without a COMMIT");

endmodule

// ==== plca_control.sv ====
`timescale 1ns/1ns

module plca_control
    import plca_pkg::*;
#(
    parameter int BEACON_LEN = 4,
    parameter int TO_CYCLES  = 8
)
(
    input  logic        TX_CLK,
    input  logic        arst_n,
    input  plca_cfg_t   cfg,
    input  rx_cmd_t     rx_cmd,
    input  logic        receiving,
    input  logic        beacon_end,
    input  logic        frame_pending,
    input  mac_nibble_t head,
    output tx_cmd_t     tx_cmd,
    output logic        pop
);

    localparam int CNT_MAX = (BEACON_LEN > TO_CYCLES) ? BEACON_LEN : TO_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    typedef logic [CNT_W-1:0] cnt_t;             // Shared BEACON timer and to_timer

    localparam cnt_t BEACON_LAST = cnt_t'(BEACON_LEN - 1);
    localparam cnt_t TO_LAST     = cnt_t'(TO_CYCLES - 2);  // NEXT_TO supplies the final cycle

    ctrl_state_t state;
    cnt_t        cnt;
    node_id_t    cur_id;                         // Opportunity now running
    node_id_t    next_id;
    logic        follower;
    logic        own_turn;
    logic        quiet_state;                    // States a received BEACON may interrupt

    assign next_id     = cur_id + 1'b1;
    assign follower    = (cfg.local_id != '0);
    assign own_turn    = (cur_id == cfg.local_id) && frame_pending;
    assign quiet_state = (state != COMMIT) && (state != TRANSMIT);

    always_ff @(posedge TX_CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= DISABLE;
            cnt    <= '0;
            cur_id <= '0;
        end
        else if (!cfg.plca_en)
        begin
            state <= DISABLE;
        end
        else if (follower && quiet_state && (rx_cmd == RX_BEACON))
        begin
            state <= WAIT_BEACON;                // Coordinator is restarting the cycle
        end
        else if (follower && quiet_state && beacon_end)
        begin
            state  <= WAIT_TO;                   // Opportunity 0 starts after the BEACON
            cnt    <= '0;
            cur_id <= '0;
        end
        else
        begin
            case (state)
                DISABLE:
                begin
                    cnt    <= '0;
                    cur_id <= '0;
                    state  <= follower ? WAIT_BEACON : SEND_BEACON;
                end
                SEND_BEACON:
                begin
                    if (cnt == BEACON_LAST)
                    begin
                        state  <= WAIT_TO;
                        cnt    <= '0;
                        cur_id <= '0;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WAIT_BEACON:
                    state <= WAIT_BEACON;        // Left only through a BEACON end
                WAIT_TO:
                begin
                    if (receiving)
                        state <= RECEIVE;        // to_timer holds while another node talks
                    else if (own_turn)
                        state <= COMMIT;
                    else if (cnt == TO_LAST)
                        state <= NEXT_TO;
                    else
                        cnt <= cnt + 1'b1;
                end
                RECEIVE:
                    if (!receiving)
                        state <= NEXT_TO;
                COMMIT:
                    state <= TRANSMIT;
                TRANSMIT:
                    if (head.last)
                        state <= NEXT_TO;        // Exactly one frame per opportunity
                NEXT_TO:
                begin
                    cnt <= '0;
                    if (next_id >= cfg.node_count)
                    begin
                        cur_id <= '0;
                        state  <= follower ? WAIT_BEACON : SEND_BEACON;
                    end
                    else
                    begin
                        cur_id <= next_id;
                        state  <= WAIT_TO;
                    end
                end
                default:
                    state <= DISABLE;
            endcase
        end
    end

    // The command is a pure decode of the state register
    always_comb
    begin
        case (state)
            SEND_BEACON: tx_cmd = TX_BEACON;
            COMMIT:      tx_cmd = TX_COMMIT;
            TRANSMIT:    tx_cmd = TX_DATA;
            default:     tx_cmd = TX_NONE;
        endcase
    end

    assign pop = (state == TRANSMIT);            // One nibble per data cycle

    // Popping needs a whole frame in the buffer until its last nibble leaves
    a_pop_in_transmit: assert property (@(posedge TX_CLK) disable iff (!arst_n)
        pop |-> frame_pending)
        else $error("Pop without a pending frame");

endmodule

// ==== plca_tx_buffer.sv ====
`timescale 1ns/1ns

module plca_tx_buffer
    import plca_pkg::*;
#(
    parameter int BUF_DEPTH = 16
)
(
    input  logic        TX_CLK,
    input  logic        arst_n,
    input  mac_nibble_t mac_in,
    input  logic        mac_valid,
    input  logic        pop,
    output mac_nibble_t head,
    output logic        frame_pending,
    output logic        credit_return
);

    localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CW = $clog2(BUF_DEPTH + 1);

    typedef logic [AW-1:0] ptr_t;                // Slot index
    typedef logic [CW-1:0] cnt_t;                // Nibble or frame count

    localparam ptr_t LAST_SLOT = ptr_t'(BUF_DEPTH - 1);

    mac_nibble_t mem [BUF_DEPTH];                // Nibble store
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    cnt_t        fill;                           // Nibbles held
    cnt_t        frames;                         // Complete frames held
    logic        push_last;
    logic        pop_last;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == LAST_SLOT) ? ptr_t'(0) : p + 1'b1;   // Wraps for any depth
    endfunction

    assign push_last = mac_valid && mac_in.last; // A frame completes in the store
    assign pop_last  = pop && head.last;         // A frame leaves the store

    always_ff @(posedge TX_CLK)
    begin
        if (mac_valid)
        begin
            mem[wr_ptr] <= mac_in;
        end
    end

    always_ff @(posedge TX_CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            frames        <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (mac_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({mac_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;          // Both or neither leave the level alone
            endcase
            case ({push_last, pop_last})
                2'b10:   frames <= frames + 1'b1;
                2'b01:   frames <= frames - 1'b1;
                default: frames <= frames;
            endcase
            credit_return <= pop;                // One credit back per nibble sent
        end
    end

    assign head          = mem[rd_ptr];
    assign frame_pending = (frames != '0);

    // The MAC spends a credit per push, so a push into a full store breaks the credit rule
    a_no_overflow: assert property (@(posedge TX_CLK) disable iff (!arst_n)
        mac_valid |-> (fill != cnt_t'(BUF_DEPTH)))
        else $error("MAC pushed a nibble without a credit");

    a_no_underflow: assert property (@(posedge TX_CLK) disable iff (!arst_n)
        pop |-> (fill != '0))
        else $error("Control popped an empty buffer");

endmodule

// ==== plca_rx_decode.sv ====
`timescale 1ns/1ns

module plca_rx_decode
    import mii_pkg::*;
    import plca_pkg::*;
(
    input  logic    TX_CLK,
    input  logic    arst_n,
    input  mii_rx_t mii_rx,
    output rx_cmd_t rx_cmd,
    output logic    receiving,
    output logic    beacon_end
);

    mii_rx_t rx_q;                               // Receive pins one cycle late
    logic    beacon_q;                           // Previous cycle decoded a BEACON

    always_ff @(posedge TX_CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_q     <= '0;                      // Quiet line
            beacon_q <= 1'b0;
        end
        else
        begin
            rx_q     <= mii_rx;
            beacon_q <= (rx_cmd == RX_BEACON);
        end
    end

    // PLCA indications carry RX_ER with RX_DV clear, everything else decodes as none
    always_comb
    begin
        case ({rx_q.rx_dv, rx_q.rx_er, rx_q.rxd})
            {1'b0, 1'b1, BEACON_CODE}: rx_cmd = RX_BEACON;
            {1'b0, 1'b1, COMMIT_CODE}: rx_cmd = RX_COMMIT;
            default:                   rx_cmd = RX_NONE;
        endcase
    end

    assign receiving  = rx_q.rx_dv || (rx_cmd == RX_COMMIT);   // Medium held by another node
    assign beacon_end = beacon_q && (rx_cmd != RX_BEACON);     // First cycle after a BEACON

    // A sender always puts a COMMIT between a BEACON and its data
    a_no_data_after_beacon: assert property (@(posedge TX_CLK) disable iff (!arst_n)
        (rx_cmd == RX_BEACON) |-> !mii_rx.rx_dv)
        else $error("RX_DV follows a BEACON indication directly");

endmodule

// ==== plca_pkg.sv ====
package plca_pkg;

    import mii_pkg::*;

    // --------------------
    // Configuration
    // --------------------

    typedef logic [7:0] node_id_t;               // Transmit opportunity number

    typedef struct packed {
        logic     plca_en;                       // PLCA function enabled
        node_id_t local_id;                      // Own opportunity, zero makes the coordinator
        node_id_t node_count;                    // Opportunities per cycle, used by the coordinator
    } plca_cfg_t;                                // Management configuration

    // --------------------
    // MAC side
    // --------------------

    typedef struct packed {
        nibble_t data;                           // Frame nibble
        logic    last;                           // Set on the final nibble of a frame
    } mac_nibble_t;                              // One MAC transfer

    // --------------------
    // Protocol enums
    // --------------------

    typedef enum logic [1:0] {
        TX_NONE,                                 // Idle on the line
        TX_BEACON,                               // Send the BEACON code
        TX_COMMIT,                               // Send the COMMIT code
        TX_DATA                                  // Send the buffer head as data
    } tx_cmd_t;

    typedef enum logic [1:0] {
        RX_NONE,
        RX_BEACON,                               // BEACON indication seen on RX
        RX_COMMIT                                // COMMIT indication seen on RX
    } rx_cmd_t;

    typedef enum logic [2:0] {
        DISABLE,                                 // PLCA off or just out of reset
        SEND_BEACON,                             // Coordinator drives BEACON
        WAIT_BEACON,                             // Follower waits for a BEACON to end
        WAIT_TO,                                 // Idle opportunity, to_timer running
        RECEIVE,                                 // Another node owns the medium
        COMMIT,                                  // One cycle of COMMIT before own data
        TRANSMIT,                                // Own frame on the line
        NEXT_TO                                  // Last cycle of an opportunity
    } ctrl_state_t;

endpackage

// ==== mii_pkg.sv ====
package mii_pkg;

    // --------------------
    // Line types
    // --------------------

    typedef logic [3:0] nibble_t;                // One MII data nibble

    typedef struct packed {
        nibble_t rxd;                            // Receive data nibble
        logic    rx_dv;                          // Receive data valid
        logic    rx_er;                          // Receive error or PLCA indication
    } mii_rx_t;                                  // Receive MII of one cycle

    typedef struct packed {
        nibble_t txd;                            // Transmit data nibble
        logic    tx_en;                          // Transmit enable
        logic    tx_er;                          // Transmit error or PLCA request
    } mii_tx_t;                                  // Transmit MII of one cycle

    // --------------------
    // PLCA line codes
    // --------------------

    // Both codes travel with TX_ER set and TX_EN clear, and arrive the same way on RX
    localparam nibble_t BEACON_CODE = 4'b0010;   // BEACON request or indication
    localparam nibble_t COMMIT_CODE = 4'b0011;   // COMMIT request or indication

endpackage
